// ==== Makefile ====
TOP := tb_trace_snooper

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

// ==== include/snooper_consts.svh ====
// Global sizing macros for the trace snooper: PC, register and address widths, buffer depth

`ifndef SNOOPER_CONSTS_SVH
`define SNOOPER_CONSTS_SVH

// Width of a program counter as reported by the core
`define SNP_PC_W 64

// Width of one configuration data word
`define SNP_REG_W 32

// Width of the configuration word address
`define SNP_ADDR_W 5

// Number of trace records held on chip, must be a power of two
`define SNP_DEPTH 16

// Buffer index width, log2 of SNP_DEPTH
`define SNP_PTR_W 4

`endif

// ==== src/snooper_cfg_pkg.sv ====
// Configuration types: control register, PC range, full configuration and register address map

`include "snooper_consts.svh"

package snooper_cfg_pkg;

   // Control word layout, most significant bit first
   typedef struct packed {
      logic       enable;
      logic [1:0] trace_mode;
      logic       m_mode;
      logic       s_mode;
      logic       u_mode;
      logic       pc_range_0;
      logic       pc_range_1;
      logic       pc_range_2;
      logic       pc_range_3;
      logic       excinh;
      logic       intrinh;
      logic       tretinh;
      logic       ntbren;
      logic       tkbrinh;
      logic       indcallinh;
      logic       dircallinh;
      logic       indjmpinh;
      logic       dirjmpinh;
      logic       corswapinh;
      logic       retinh;
      logic       indljmpinh;
      logic       dirljmpinh;
      logic [8:0] reserved;
   } ctrl_reg_t;

   localparam int unsigned CFG_NUM_RANGES = 4;

   // Inclusive bounds of one source PC window
   typedef struct packed {
      snooper_pkg::pc_t base;
      snooper_pkg::pc_t last;
   } pc_range_t;

   typedef struct packed {
      ctrl_reg_t                            ctrl;
      pc_range_t [CFG_NUM_RANGES-1:0]       pc_range;
   } snooper_cfg_t;

   typedef logic [`SNP_ADDR_W-1:0] cfg_addr_t;

   // Word address map, range n starts at CFG_ADDR_RANGE0 + CFG_RANGE_STRIDE * n
   localparam int unsigned CFG_ADDR_CTRL    = 0;
   localparam int unsigned CFG_ADDR_RANGE0  = 1;
   localparam int unsigned CFG_RANGE_STRIDE = 4;
   localparam int unsigned CFG_OFS_BASE_L   = 0;
   localparam int unsigned CFG_OFS_BASE_H   = 1;
   localparam int unsigned CFG_OFS_LAST_L   = 2;
   localparam int unsigned CFG_OFS_LAST_H   = 3;
   localparam int unsigned CFG_NUM_WORDS    = CFG_ADDR_RANGE0 + CFG_RANGE_STRIDE * CFG_NUM_RANGES;

endpackage

// ==== src/snooper_cfg_regs.sv ====
// Configuration register file: word decode, storage and assembly of the configuration struct

`timescale 1ns/1ps

`include "snooper_consts.svh"

module snooper_cfg_regs (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          cfg_we_i,
   input  snooper_cfg_pkg::cfg_addr_t    cfg_addr_i,
   input  logic [`SNP_REG_W-1:0]         cfg_wdata_i,
   output snooper_cfg_pkg::snooper_cfg_t cfg_o
);

   logic [`SNP_REG_W-1:0] words_q [snooper_cfg_pkg::CFG_NUM_WORDS];
   logic                  addr_hit;

   // Anything past the last range word is not mapped
   assign addr_hit = cfg_addr_i <
                     snooper_cfg_pkg::cfg_addr_t'(snooper_cfg_pkg::CFG_NUM_WORDS);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int w = 0; w < snooper_cfg_pkg::CFG_NUM_WORDS; w++) begin
            words_q[w] <= '0;
         end
      end else if (cfg_we_i && addr_hit) begin
         words_q[cfg_addr_i] <= cfg_wdata_i;
      end
   end

   // Each 64-bit bound is split over a low and a high word
   always_comb begin : assemble
      int unsigned base_addr;

      cfg_o.ctrl = snooper_cfg_pkg::ctrl_reg_t'(words_q[snooper_cfg_pkg::CFG_ADDR_CTRL]);
      for (int n = 0; n < snooper_cfg_pkg::CFG_NUM_RANGES; n++) begin
         base_addr = snooper_cfg_pkg::CFG_ADDR_RANGE0 + snooper_cfg_pkg::CFG_RANGE_STRIDE * n;
         cfg_o.pc_range[n].base = snooper_pkg::pc_t'({
            words_q[base_addr + snooper_cfg_pkg::CFG_OFS_BASE_H],
            words_q[base_addr + snooper_cfg_pkg::CFG_OFS_BASE_L]
         });
         cfg_o.pc_range[n].last = snooper_pkg::pc_t'({
            words_q[base_addr + snooper_cfg_pkg::CFG_OFS_LAST_H],
            words_q[base_addr + snooper_cfg_pkg::CFG_OFS_LAST_L]
         });
      end
   end

endmodule

// ==== src/snooper_ctrl.sv ====
// Capture control: IDLE/ARMED/FULL FSM, occupancy counter, buffer write and read enables

`timescale 1ns/1ps

`include "snooper_consts.svh"

module snooper_ctrl (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  snooper_cfg_pkg::snooper_cfg_t cfg_i,
   input  logic                          keep_i,
   input  logic                          rd_req_i,
   output logic                          wr_en_o,
   output logic                          rd_en_o,
   output snooper_pkg::count_t           count_o,
   output logic                          full_o,
   output logic                          armed_o
);

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_ARMED = 2'd1,
      ST_FULL  = 2'd2
   } state_e;

   state_e              state_q;
   state_e              state_d;
   snooper_pkg::count_t count_q;
   snooper_pkg::count_t count_d;
   logic                at_depth;

   assign at_depth = (count_q == snooper_pkg::count_t'(`SNP_DEPTH));

   // at_depth only matters when capture is re-armed over a buffer left full
   assign wr_en_o = (state_q == ST_ARMED) && keep_i && !at_depth;
   assign rd_en_o = rd_req_i && (count_q != '0);

   always_comb begin : count_next
      case ({wr_en_o, rd_en_o})
         2'b10:   count_d = count_q + snooper_pkg::count_t'(1);
         2'b01:   count_d = count_q - snooper_pkg::count_t'(1);
         default: count_d = count_q;
      endcase
   end

   always_comb begin : fsm_next
      state_d = state_q;
      if (!cfg_i.ctrl.enable) begin
         state_d = ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE:  state_d = ST_ARMED;
            ST_ARMED: begin
               if (count_d == snooper_pkg::count_t'(`SNP_DEPTH)) begin
                  state_d = ST_FULL;
               end
            end
            ST_FULL:  begin
               if (rd_en_o) begin
                  state_d = ST_ARMED;
               end
            end
            default:  state_d = ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         count_q <= '0;
      end else begin
         state_q <= state_d;
         count_q <= count_d;
      end
   end

   assign count_o = count_q;
   assign full_o  = (state_q == ST_FULL);
   assign armed_o = (state_q == ST_ARMED);

endmodule

// ==== src/snooper_pkg.sv ====
// Trace record types: PC, transfer type, privilege level, record struct, buffer index and count

`include "snooper_consts.svh"

package snooper_pkg;

   typedef logic [`SNP_PC_W-1:0] pc_t;

   // Control transfer type codes as reported by the core
   typedef enum logic [3:0] {
      CTR_TYPE_NONE    = 4'd0,
      CTR_TYPE_EXC     = 4'd1,
      CTR_TYPE_INTR    = 4'd2,
      CTR_TYPE_TRET    = 4'd3,
      CTR_TYPE_NTBR    = 4'd4,
      CTR_TYPE_TKBR    = 4'd5,
      CTR_TYPE_INDCALL = 4'd6,
      CTR_TYPE_DIRCALL = 4'd7,
      CTR_TYPE_INDJMP  = 4'd8,
      CTR_TYPE_DIRJMP  = 4'd9,
      CTR_TYPE_CORSWAP = 4'd10,
      CTR_TYPE_RET     = 4'd11,
      CTR_TYPE_INDLJMP = 4'd12,
      CTR_TYPE_DIRLJMP = 4'd13
   } ctr_type_e;

   // Code 2 is reserved by the privileged spec
   typedef enum logic [1:0] {
      PRIV_LVL_U = 2'd0,
      PRIV_LVL_S = 2'd1,
      PRIV_LVL_M = 2'd3
   } priv_lvl_e;

   typedef struct packed {
      pc_t       pc_src;
      pc_t       pc_dst;
      ctr_type_e ctr_type;
      priv_lvl_e priv_lvl;
   } trace_t;

   typedef logic [`SNP_PTR_W-1:0] ptr_t;

   // One bit wider than the index so a full buffer can be told from an empty one
   typedef logic [`SNP_PTR_W:0] count_t;

endpackage

// ==== src/trace_buffer.sv ====
// Trace ring buffer: record storage, write and read pointers, registered read port

`timescale 1ns/1ps

`include "snooper_consts.svh"

module trace_buffer (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                wr_en_i,
   input  snooper_pkg::trace_t wr_data_i,
   input  logic                rd_en_i,
   output logic                rd_valid_o,
   output snooper_pkg::trace_t rd_data_o
);

   snooper_pkg::trace_t mem_q [`SNP_DEPTH];
   snooper_pkg::ptr_t   wr_ptr_q;
   snooper_pkg::ptr_t   rd_ptr_q;
   logic                rd_valid_q;
   snooper_pkg::trace_t rd_data_q;

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + snooper_pkg::ptr_t'(1);
         end
         if (rd_en_i) begin
            rd_ptr_q <= rd_ptr_q + snooper_pkg::ptr_t'(1);
         end
         rd_valid_q <= rd_en_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem_q[wr_ptr_q] <= wr_data_i;
      end
   end

   // The control never reads an empty buffer, so the read slot is never the one
   // being written in the same cycle
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= mem_q[rd_ptr_q];
      end
   end

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = rd_data_q;

endmodule

// ==== src/trace_filter.sv ====
// Trace filter: keep or drop one record by type, privilege, trace mode and PC range

`timescale 1ns/1ps

module trace_filter (
   input  snooper_pkg::trace_t           trace_i,
   input  snooper_cfg_pkg::snooper_cfg_t cfg_i,
   input  logic                          trace_valid_i,
   output logic                          keep_o
);

   logic                                       type_en;
   logic                                       priv_en;
   logic                                       instr_en;
   logic [snooper_cfg_pkg::CFG_NUM_RANGES-1:0] range_en;
   logic [snooper_cfg_pkg::CFG_NUM_RANGES-1:0] range_hit;

   // NONE and the two unused codes fall to the default arm and are never kept here
   always_comb begin : type_filter
      case (trace_i.ctr_type)
         snooper_pkg::CTR_TYPE_EXC:     type_en = ~cfg_i.ctrl.excinh;
         snooper_pkg::CTR_TYPE_INTR:    type_en = ~cfg_i.ctrl.intrinh;
         snooper_pkg::CTR_TYPE_TRET:    type_en = ~cfg_i.ctrl.tretinh;
         snooper_pkg::CTR_TYPE_NTBR:    type_en = ~cfg_i.ctrl.ntbren;
         snooper_pkg::CTR_TYPE_TKBR:    type_en = ~cfg_i.ctrl.tkbrinh;
         snooper_pkg::CTR_TYPE_INDCALL: type_en = ~cfg_i.ctrl.indcallinh;
         snooper_pkg::CTR_TYPE_DIRCALL: type_en = ~cfg_i.ctrl.dircallinh;
         snooper_pkg::CTR_TYPE_INDJMP:  type_en = ~cfg_i.ctrl.indjmpinh;
         snooper_pkg::CTR_TYPE_DIRJMP:  type_en = ~cfg_i.ctrl.dirjmpinh;
         snooper_pkg::CTR_TYPE_CORSWAP: type_en = ~cfg_i.ctrl.corswapinh;
         snooper_pkg::CTR_TYPE_RET:     type_en = ~cfg_i.ctrl.retinh;
         snooper_pkg::CTR_TYPE_INDLJMP: type_en = ~cfg_i.ctrl.indljmpinh;
         snooper_pkg::CTR_TYPE_DIRLJMP: type_en = ~cfg_i.ctrl.dirljmpinh;
         default:                       type_en = 1'b0;
      endcase
   end

   // Instruction trace mode bypasses the type check entirely
   assign instr_en = (cfg_i.ctrl.trace_mode == 2'b01);

   always_comb begin : priv_filter
      case (trace_i.priv_lvl)
         snooper_pkg::PRIV_LVL_M: priv_en = cfg_i.ctrl.m_mode;
         snooper_pkg::PRIV_LVL_S: priv_en = cfg_i.ctrl.s_mode;
         snooper_pkg::PRIV_LVL_U: priv_en = cfg_i.ctrl.u_mode;
         default:                 priv_en = 1'b0;
      endcase
   end

   assign range_en = {
      cfg_i.ctrl.pc_range_3,
      cfg_i.ctrl.pc_range_2,
      cfg_i.ctrl.pc_range_1,
      cfg_i.ctrl.pc_range_0
   };

   // Both bounds are inclusive; a range with base above last never matches
   always_comb begin : range_filter
      for (int n = 0; n < snooper_cfg_pkg::CFG_NUM_RANGES; n++) begin
         range_hit[n] = range_en[n] &&
                        (cfg_i.pc_range[n].base <= trace_i.pc_src) &&
                        (trace_i.pc_src <= cfg_i.pc_range[n].last);
      end
   end

   assign keep_o = trace_valid_i &
                   priv_en &
                   (instr_en | type_en) &
                   (|range_hit);

endmodule

// ==== src/trace_snooper_top.sv ====
// Trace snooper top level: register file, filter, capture control and ring buffer

`timescale 1ns/1ps

module trace_snooper_top (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       cfg_we_i,
   input  snooper_cfg_pkg::cfg_addr_t cfg_addr_i,
   input  logic [31:0]                cfg_wdata_i,
   input  logic                       trace_valid_i,
   input  snooper_pkg::trace_t        trace_i,
   input  logic                       rd_req_i,
   output logic                       rd_valid_o,
   output snooper_pkg::trace_t        rd_data_o,
   output snooper_pkg::count_t        count_o,
   output logic                       full_o,
   output logic                       armed_o
);

   snooper_cfg_pkg::snooper_cfg_t cfg;
   logic                          keep;
   logic                          wr_en;
   logic                          rd_en;

   snooper_cfg_regs u_cfg_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_o       (cfg)
   );

   trace_filter u_filter (
      .trace_i       (trace_i),
      .cfg_i         (cfg),
      .trace_valid_i (trace_valid_i),
      .keep_o        (keep)
   );

   snooper_ctrl u_ctrl (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cfg_i    (cfg),
      .keep_i   (keep),
      .rd_req_i (rd_req_i),
      .wr_en_o  (wr_en),
      .rd_en_o  (rd_en),
      .count_o  (count_o),
      .full_o   (full_o),
      .armed_o  (armed_o)
   );

   // The record goes straight from the core to the buffer, the filter only gates it
   trace_buffer u_buffer (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_en_i    (wr_en),
      .wr_data_i  (trace_i),
      .rd_en_i    (rd_en),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o)
   );

endmodule

// ==== test/snooper_assertions.sv ====
// Concurrent checks on the snooper top level: read latency, occupancy, reset state, arming

`timescale 1ns/1ps

`include "snooper_consts.svh"

module snooper_assertions (
   input logic                clk_i,
   input logic                rst_i,
   input logic                rd_req_i,
   input logic                rd_valid_i,
   input snooper_pkg::count_t count_i,
   input logic                full_i,
   input logic                armed_i,
   input logic                enable_i
);

   // A request counts as accepted only while the buffer holds something
   read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      (rd_req_i && count_i != '0) |=> rd_valid_i)
      else $error("Read data did not follow an accepted request");

   no_stray_valid: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_i |-> $past(rd_req_i && count_i != '0))
      else $error("Read data appeared without an accepted request");

   count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      count_i <= snooper_pkg::count_t'(`SNP_DEPTH))
      else $error("Occupancy went past the buffer depth");

   full_no_growth: assert property (@(posedge clk_i) disable iff (rst_i)
      full_i |=> count_i <= $past(count_i))
      else $error("Occupancy grew while the buffer was full");

   reset_state: assert property (@(posedge clk_i)
      rst_i |=> (!full_i && !armed_i))
      else $error("FSM not idle after reset");

   // The state register needs one edge to see a cleared enable
   disarm: assert property (@(posedge clk_i) disable iff (rst_i)
      !enable_i |=> !armed_i)
      else $error("Capture stayed armed with enable clear");

endmodule

bind trace_snooper_top snooper_assertions u_sva (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .rd_req_i   (rd_req_i),
   .rd_valid_i (rd_valid_o),
   .count_i    (count_o),
   .full_i     (full_o),
   .armed_i    (armed_o),
   .enable_i   (cfg.ctrl.enable)
);

// ==== test/tb_trace_snooper.sv ====
// Snooper testbench: clock, reset, configuration, random records, reference filter, drain

`timescale 1ns/1ps

`include "snooper_consts.svh"

module tb_trace_snooper;

   logic                       clk;
   logic                       rst;
   logic                       cfg_we;
   snooper_cfg_pkg::cfg_addr_t cfg_addr;
   logic [`SNP_REG_W-1:0]      cfg_wdata;
   logic                       trace_valid;
   snooper_pkg::trace_t        trace;
   logic                       rd_req;
   logic                       rd_valid;
   snooper_pkg::trace_t        rd_data;
   snooper_pkg::count_t        count;
   logic                       full;
   logic                       armed;

   // Shadow of the programmed registers for the reference filter
   snooper_cfg_pkg::ctrl_reg_t ctrl;
   snooper_cfg_pkg::pc_range_t ranges [4];
   snooper_pkg::trace_t        exp_q [$];

   trace_snooper_top u_dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .cfg_we_i      (cfg_we),
      .cfg_addr_i    (cfg_addr),
      .cfg_wdata_i   (cfg_wdata),
      .trace_valid_i (trace_valid),
      .trace_i       (trace),
      .rd_req_i      (rd_req),
      .rd_valid_o    (rd_valid),
      .rd_data_o     (rd_data),
      .count_o       (count),
      .full_o        (full),
      .armed_o       (armed)
   );

   always #20 clk = ~clk;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("sim failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic write_word(input int unsigned addr, input logic [31:0] data);
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_addr  = snooper_cfg_pkg::cfg_addr_t'(addr);
      cfg_wdata = data;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   task automatic write_ctrl(input snooper_cfg_pkg::ctrl_reg_t value);
      ctrl = value;
      write_word(0, value);
   endtask

   // Range n occupies four words from 1 + 4n
   task automatic write_range(input int n, input snooper_pkg::pc_t base,
                              input snooper_pkg::pc_t last);
      ranges[n].base = base;
      ranges[n].last = last;
      write_word(1 + 4 * n, base[31:0]);
      write_word(2 + 4 * n, base[63:32]);
      write_word(3 + 4 * n, last[31:0]);
      write_word(4 + 4 * n, last[63:32]);
   endtask

   function automatic bit model_keep(input snooper_pkg::trace_t t);
      logic [15:0] type_ok;
      logic [3:0]  priv_ok;
      logic [3:0]  rng_en;
      bit          in_range;

      // Bit k allows type code k; NONE and codes 14 and 15 are never allowed
      type_ok = {2'b00, ~{ctrl.dirljmpinh, ctrl.indljmpinh, ctrl.retinh, ctrl.corswapinh,
                          ctrl.dirjmpinh, ctrl.indjmpinh, ctrl.dircallinh, ctrl.indcallinh,
                          ctrl.tkbrinh, ctrl.ntbren, ctrl.tretinh, ctrl.intrinh,
                          ctrl.excinh}, 1'b0};
      priv_ok = {ctrl.m_mode, 1'b0, ctrl.s_mode, ctrl.u_mode};
      rng_en  = {ctrl.pc_range_3, ctrl.pc_range_2, ctrl.pc_range_1, ctrl.pc_range_0};
      in_range = 1'b0;
      for (int n = 0; n < 4; n++) begin
         if (rng_en[n] && t.pc_src >= ranges[n].base && t.pc_src <= ranges[n].last) begin
            in_range = 1'b1;
         end
      end
      return priv_ok[t.priv_lvl] && in_range &&
             (ctrl.trace_mode == 2'b01 || type_ok[t.ctr_type]);
   endfunction

   function automatic snooper_pkg::trace_t rand_record(input snooper_pkg::pc_t center,
                                                       input int unsigned span);
      snooper_pkg::trace_t t;

      t.pc_src   = center - snooper_pkg::pc_t'(span) +
                   snooper_pkg::pc_t'($urandom_range(2 * span));
      t.pc_dst   = {$urandom, $urandom};
      t.ctr_type = snooper_pkg::ctr_type_e'(4'($urandom_range(15)));
      t.priv_lvl = snooper_pkg::priv_lvl_e'(2'($urandom_range(3)));
      return t;
   endfunction

   // A record is accepted while capture is on and the buffer has room
   task automatic offer(input snooper_pkg::trace_t t);
      @(negedge clk);
      trace_valid = 1'b1;
      trace       = t;
      @(negedge clk);
      trace_valid = 1'b0;
      if (ctrl.enable && model_keep(t) && exp_q.size() < `SNP_DEPTH) begin
         exp_q.push_back(t);
      end
      assert (count == snooper_pkg::count_t'(exp_q.size()))
         else stop_run($sformatf("[FAIL] %0t: count is %0d, expected %0d",
                                 $time, count, exp_q.size()));
   endtask

   task automatic read_check();
      snooper_pkg::trace_t want;
      int                  waited;

      @(negedge clk);
      rd_req = 1'b1;
      @(negedge clk);
      rd_req = 1'b0;
      waited = 0;
      while (!rd_valid) begin
         if (waited == 100) begin
            stop_run("Read data never arrived within 100 cycles of the request");
         end
         @(negedge clk);
         waited++;
      end
      want = exp_q.pop_front();
      assert (rd_data == want)
         else stop_run($sformatf("[FAIL] %0t: read %h, expected %h", $time, rd_data, want));
   endtask

   task automatic offer_and_drain(input snooper_pkg::trace_t t);
      offer(t);
      while (exp_q.size() != 0) begin
         read_check();
      end
   endtask

   initial begin
      snooper_cfg_pkg::ctrl_reg_t c;
      snooper_pkg::trace_t        rec;
      snooper_pkg::pc_t           base;

      void'($urandom(32'h3e32a087));
      clk         = 1'b0;
      rst         = 1'b1;
      cfg_we      = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      trace_valid = 1'b0;
      trace       = '0;
      rd_req      = 1'b0;
      ctrl        = '0;
      for (int n = 0; n < 4; n++) begin
         ranges[n] = '0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Capture off, so nothing is stored and an empty read returns nothing
      for (int i = 0; i < 20; i++) begin
         offer(rand_record(64'h1000, 64));
         assert (!armed) else stop_run($sformatf("[FAIL] %0t: armed while disabled", $time));
      end
      @(negedge clk);
      rd_req = 1'b1;
      @(negedge clk);
      rd_req = 1'b0;
      assert (!rd_valid) else stop_run($sformatf("[FAIL] %0t: read data from empty", $time));

      // M mode and range 0 only
      write_range(0, 64'h8000_0000_0000_1000, 64'h8000_0000_0000_10ff);
      c            = '0;
      c.enable     = 1'b1;
      c.m_mode     = 1'b1;
      c.pc_range_0 = 1'b1;
      write_ctrl(c);
      for (int i = 0; i < 200; i++) begin
         offer_and_drain(rand_record(64'h8000_0000_0000_1080, 'h100));
      end

      // Random inhibit masks over every type code, then instruction mode
      write_range(0, '0, '1);
      c.s_mode = 1'b1;
      c.u_mode = 1'b1;
      for (int k = 0; k < 4; k++) begin
         {c.excinh, c.intrinh, c.tretinh, c.ntbren, c.tkbrinh, c.indcallinh, c.dircallinh,
          c.indjmpinh, c.dirjmpinh, c.corswapinh, c.retinh, c.indljmpinh,
          c.dirljmpinh} = 13'($urandom);
         c.trace_mode = (k == 3) ? 2'b01 : 2'b00;
         write_ctrl(c);
         for (int i = 0; i < 32; i++) begin
            rec          = rand_record(64'h4000, 256);
            rec.ctr_type = snooper_pkg::ctr_type_e'(4'(i));
            rec.priv_lvl = snooper_pkg::PRIV_LVL_U;
            offer_and_drain(rec);
         end
      end

      // Four ranges probed one below, at, and one past each bound
      for (int n = 0; n < 4; n++) begin
         base = 64'h10000 * snooper_pkg::pc_t'(n + 1);
         write_range(n, base, base + 64'h3f);
      end
      {c.pc_range_0, c.pc_range_1, c.pc_range_2, c.pc_range_3} = 4'hf;
      write_ctrl(c);
      for (int n = 0; n < 4; n++) begin
         for (int p = 0; p < 4; p++) begin
            rec          = rand_record(64'h0, 0);
            rec.priv_lvl = snooper_pkg::PRIV_LVL_S;
            case (p)
               0:       rec.pc_src = ranges[n].base - 64'd1;
               1:       rec.pc_src = ranges[n].base;
               2:       rec.pc_src = ranges[n].last;
               default: rec.pc_src = ranges[n].last + 64'd1;
            endcase
            offer_and_drain(rec);
         end
      end

      // Fill past the depth, then one read re-arms capture
      for (int i = 0; i < `SNP_DEPTH + 4; i++) begin
         rec          = rand_record(64'h10020, 16);
         rec.priv_lvl = snooper_pkg::PRIV_LVL_M;
         offer(rec);
      end
      assert (full && count == snooper_pkg::count_t'(`SNP_DEPTH))
         else stop_run($sformatf("[FAIL] %0t: full %0b count %0d", $time, full, count));
      read_check();
      assert (armed) else stop_run($sformatf("[FAIL] %0t: not armed after a read", $time));
      rec          = rand_record(64'h10020, 16);
      rec.priv_lvl = snooper_pkg::PRIV_LVL_M;
      offer(rec);
      while (exp_q.size() != 0) begin
         read_check();
      end

      // Disabling stops capture but buffered records remain readable
      for (int i = 0; i < 3; i++) begin
         rec          = rand_record(64'h20020, 16);
         rec.priv_lvl = snooper_pkg::PRIV_LVL_M;
         offer(rec);
      end
      c.enable = 1'b0;
      write_ctrl(c);
      @(negedge clk);
      assert (!armed) else stop_run($sformatf("[FAIL] %0t: armed after disable", $time));
      rec          = rand_record(64'h20020, 16);
      rec.priv_lvl = snooper_pkg::PRIV_LVL_M;
      offer(rec);
      while (exp_q.size() != 0) begin
         read_check();
      end

      $display("sim passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
src/snooper_pkg.sv
src/snooper_cfg_pkg.sv
src/snooper_cfg_regs.sv
src/trace_filter.sv
src/trace_buffer.sv
src/snooper_ctrl.sv
src/trace_snooper_top.sv
test/snooper_assertions.sv
test/tb_trace_snooper.sv
